/* verilog/ex_pkg.sv */
package ex_pkg;

    // register word and hi/lo pair widths
    localparam int WORD_W     = 32;
    localparam int DWORD_W    = 64;

    // register number and shift amount
    localparam int REG_ADDR_W = 5;
    localparam int SHAMT_W    = 5;

    // executed operations, aluop encoding of the decode stage
    typedef enum logic [7:0] {
        EXE_NOP_OP   = 8'b0000_0000,
        // bitwise logic
        EXE_AND_OP   = 8'b0010_0100,
        EXE_OR_OP    = 8'b0010_0101,
        EXE_XOR_OP   = 8'b0010_0110,
        EXE_NOR_OP   = 8'b0010_0111,
        // shifts
        EXE_SLL_OP   = 8'b0111_1100,
        EXE_SRL_OP   = 8'b0000_0010,
        EXE_SRA_OP   = 8'b0000_0011,
        // add / sub, with and without trap on overflow
        EXE_ADD_OP   = 8'b0010_0000,
        EXE_ADDU_OP  = 8'b0010_0001,
        EXE_SUB_OP   = 8'b0010_0010,
        EXE_SUBU_OP  = 8'b0010_0011,
        // set on less than
        EXE_SLT_OP   = 8'b0010_1010,
        EXE_SLTU_OP  = 8'b0010_1011,
        // conditional moves and hi/lo access
        EXE_MOVZ_OP  = 8'b0000_1010,
        EXE_MOVN_OP  = 8'b0000_1011,
        EXE_MFHI_OP  = 8'b0001_0000,
        EXE_MTHI_OP  = 8'b0001_0001,
        EXE_MFLO_OP  = 8'b0001_0010,
        EXE_MTLO_OP  = 8'b0001_0011,
        // multiplies
        EXE_MULT_OP  = 8'b0001_1000,
        EXE_MULTU_OP = 8'b0001_1001,
        EXE_MUL_OP   = 8'b1010_1001
    } alu_op_e;

    // result classes picked by the output mux
    typedef enum logic [2:0] {
        EXE_RES_NONE  = 3'b000,
        EXE_RES_LOGIC = 3'b001,
        EXE_RES_SHIFT = 3'b010,
        EXE_RES_MOVE  = 3'b011,
        EXE_RES_ARITH = 3'b100,
        EXE_RES_MUL   = 3'b101
    } alu_sel_e;

endpackage

/* verilog/ex_logic_shift.sv */
module ex_logic_shift (
    input  ex_pkg::alu_op_e               aluop_i,
    input  logic [ex_pkg::WORD_W-1:0]     reg1_i,
    input  logic [ex_pkg::WORD_W-1:0]     reg2_i,
    output logic [ex_pkg::WORD_W-1:0]     result_o
);

    import ex_pkg::*;

    // shift amount comes from rs low bits
    logic [SHAMT_W-1:0] shamt;

    assign shamt = reg1_i[SHAMT_W-1:0];

    always_comb
    begin
        case (aluop_i)
            // plain bitwise ops
            EXE_AND_OP:
            begin
                result_o = reg1_i & reg2_i;
            end
            EXE_OR_OP:
            begin
                result_o = reg1_i | reg2_i;
            end
            EXE_XOR_OP:
            begin
                result_o = reg1_i ^ reg2_i;
            end
            EXE_NOR_OP:
            begin
                result_o = ~(reg1_i | reg2_i);
            end
            // rt is the shifted value
            EXE_SLL_OP:
            begin
                result_o = reg2_i << shamt;
            end
            EXE_SRL_OP:
            begin
                result_o = reg2_i >> shamt;
            end
            // sign bit replicated from the top
            EXE_SRA_OP:
            begin
                result_o = $signed(reg2_i) >>> shamt;
            end
            default:
            begin
                result_o = '0;
            end
        endcase
    end

endmodule

/* verilog/ex_arith.sv */
module ex_arith (
    input  ex_pkg::alu_op_e               aluop_i,
    input  logic [ex_pkg::WORD_W-1:0]     reg1_i,
    input  logic [ex_pkg::WORD_W-1:0]     reg2_i,
    output logic [ex_pkg::WORD_W-1:0]     result_o,
    output logic                          ovf_o
);

    import ex_pkg::*;

    logic [WORD_W-1:0] sum;
    logic [WORD_W-1:0] diff;
    logic              ovf_add;
    logic              ovf_sub;
    logic              lt_s;
    logic              lt_u;

    // shared adder and subtractor, wrap around
    assign sum  = reg1_i + reg2_i;
    assign diff = reg1_i - reg2_i;

    // add overflows when equal signs give the other sign
    assign ovf_add = (reg1_i[WORD_W-1] == reg2_i[WORD_W-1]) &&
                     (sum[WORD_W-1] != reg1_i[WORD_W-1]);

    // sub overflows when opposite signs flip the minuend sign
    assign ovf_sub = (reg1_i[WORD_W-1] != reg2_i[WORD_W-1]) &&
                     (diff[WORD_W-1] != reg1_i[WORD_W-1]);

    // signed and unsigned order
    assign lt_s = $signed(reg1_i) < $signed(reg2_i);
    assign lt_u = reg1_i < reg2_i;

    // only ADD and SUB report overflow
    assign ovf_o = ((aluop_i == EXE_ADD_OP) && ovf_add) ||
                   ((aluop_i == EXE_SUB_OP) && ovf_sub);

    always_comb
    begin
        case (aluop_i)
            EXE_ADD_OP, EXE_ADDU_OP:
            begin
                result_o = sum;
            end
            EXE_SUB_OP, EXE_SUBU_OP:
            begin
                result_o = diff;
            end
            // compare result is 0 or 1
            EXE_SLT_OP:
            begin
                result_o = {{(WORD_W-1){1'b0}}, lt_s};
            end
            EXE_SLTU_OP:
            begin
                result_o = {{(WORD_W-1){1'b0}}, lt_u};
            end
            default:
            begin
                result_o = '0;
            end
        endcase
    end

endmodule

/* verilog/ex_mult.sv */
module ex_mult (
    input  logic [ex_pkg::WORD_W-1:0]     reg1_i,
    input  logic [ex_pkg::WORD_W-1:0]     reg2_i,
    output logic [ex_pkg::DWORD_W-1:0]    prod_s_o,
    output logic [ex_pkg::DWORD_W-1:0]    prod_u_o
);

    import ex_pkg::*;

    logic [WORD_W-1:0]  mag1;
    logic [WORD_W-1:0]  mag2;
    logic [DWORD_W-1:0] prod_mag;
    logic               neg;

    // operand magnitudes, two's complement when negative
    // most negative word maps to 2^31, still fits unsigned
    assign mag1 = reg1_i[WORD_W-1] ? (~reg1_i + 1'b1) : reg1_i;
    assign mag2 = reg2_i[WORD_W-1] ? (~reg2_i + 1'b1) : reg2_i;

    // magnitude product, full width
    assign prod_mag = DWORD_W'(mag1) * DWORD_W'(mag2);

    // product sign from operand signs
    assign neg = reg1_i[WORD_W-1] ^ reg2_i[WORD_W-1];

    always_comb
    begin
        if (neg)
        begin
            prod_s_o = ~prod_mag + 1'b1;
        end
        else
        begin
            prod_s_o = prod_mag;
        end
    end

    // MULTU treats both words as unsigned
    assign prod_u_o = DWORD_W'(reg1_i) * DWORD_W'(reg2_i);

endmodule

/* verilog/ex_hilo.sv */
module ex_hilo (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          valid_i,
    input  ex_pkg::alu_op_e               aluop_i,
    input  logic [ex_pkg::WORD_W-1:0]     reg1_i,
    input  logic [ex_pkg::DWORD_W-1:0]    prod_s_i,
    input  logic [ex_pkg::DWORD_W-1:0]    prod_u_i,
    output logic [ex_pkg::WORD_W-1:0]     hi_o,
    output logic [ex_pkg::WORD_W-1:0]     lo_o
);

    import ex_pkg::*;

    logic [WORD_W-1:0] hi_q;
    logic [WORD_W-1:0] lo_q;

    // written at the issuing edge
    // so an MFHI/MFLO in the next cycle sees the new pair
    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            hi_q <= '0;
            lo_q <= '0;
        end
        else if (valid_i)
        begin
            case (aluop_i)
                // one half only, other half kept
                EXE_MTHI_OP:
                begin
                    hi_q <= reg1_i;
                end
                EXE_MTLO_OP:
                begin
                    lo_q <= reg1_i;
                end
                // full product into both halves
                EXE_MULT_OP:
                begin
                    hi_q <= prod_s_i[DWORD_W-1:WORD_W];
                    lo_q <= prod_s_i[WORD_W-1:0];
                end
                EXE_MULTU_OP:
                begin
                    hi_q <= prod_u_i[DWORD_W-1:WORD_W];
                    lo_q <= prod_u_i[WORD_W-1:0];
                end
                default:
                begin
                    hi_q <= hi_q;
                    lo_q <= lo_q;
                end
            endcase
        end
    end

    // current pair for MFHI/MFLO
    assign hi_o = hi_q;
    assign lo_o = lo_q;

endmodule

/* verilog/ex_result_mux.sv */
module ex_result_mux (
    input  logic                              clk,
    input  logic                              rst_n_i,
    input  logic                              valid_i,
    input  ex_pkg::alu_op_e                   aluop_i,
    input  logic [ex_pkg::WORD_W-1:0]         reg1_i,
    input  logic [ex_pkg::WORD_W-1:0]         reg2_i,
    input  logic [ex_pkg::REG_ADDR_W-1:0]     wd_i,
    input  logic                              wreg_i,
    input  logic [ex_pkg::WORD_W-1:0]         logic_i,
    input  logic [ex_pkg::WORD_W-1:0]         arith_i,
    input  logic                              ovf_i,
    input  logic [ex_pkg::DWORD_W-1:0]        prod_s_i,
    input  logic [ex_pkg::WORD_W-1:0]         hi_i,
    input  logic [ex_pkg::WORD_W-1:0]         lo_i,
    output logic                              valid_o,
    output logic [ex_pkg::WORD_W-1:0]         wdata_o,
    output logic [ex_pkg::REG_ADDR_W-1:0]     wd_o,
    output logic                              wreg_o,
    output logic                              ovf_o
);

    import ex_pkg::*;

    alu_sel_e          sel;
    logic [WORD_W-1:0] move_word;
    logic [WORD_W-1:0] wdata_d;
    logic              rt_zero;
    logic              mov_cancel;
    logic              wreg_d;

    // result class follows from the opcode
    always_comb
    begin
        case (aluop_i)
            EXE_AND_OP, EXE_OR_OP, EXE_XOR_OP, EXE_NOR_OP:
                sel = EXE_RES_LOGIC;
            EXE_SLL_OP, EXE_SRL_OP, EXE_SRA_OP:
                sel = EXE_RES_SHIFT;
            EXE_ADD_OP, EXE_ADDU_OP, EXE_SUB_OP, EXE_SUBU_OP, EXE_SLT_OP, EXE_SLTU_OP:
                sel = EXE_RES_ARITH;
            EXE_MOVZ_OP, EXE_MOVN_OP, EXE_MFHI_OP, EXE_MFLO_OP:
                sel = EXE_RES_MOVE;
            EXE_MUL_OP:
                sel = EXE_RES_MUL;
            default:
                sel = EXE_RES_NONE;
        endcase
    end

    // move class, rs for the conditional moves
    always_comb
    begin
        case (aluop_i)
            EXE_MFHI_OP: move_word = hi_i;
            EXE_MFLO_OP: move_word = lo_i;
            default:     move_word = reg1_i;
        endcase
    end

    // logic and shift share one unit output
    always_comb
    begin
        case (sel)
            EXE_RES_LOGIC, EXE_RES_SHIFT: wdata_d = logic_i;
            EXE_RES_ARITH:                wdata_d = arith_i;
            EXE_RES_MOVE:                 wdata_d = move_word;
            EXE_RES_MUL:                  wdata_d = prod_s_i[WORD_W-1:0];
            default:                      wdata_d = '0;
        endcase
    end

    // MOVZ needs rt zero, MOVN needs rt non-zero
    assign rt_zero    = (reg2_i == '0);
    assign mov_cancel = ((aluop_i == EXE_MOVZ_OP) && !rt_zero) ||
                        ((aluop_i == EXE_MOVN_OP) && rt_zero);

    // trapped overflow also kills the write
    assign wreg_d = wreg_i && !ovf_i && !mov_cancel;

    // single output stage
    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            valid_o <= 1'b0;
            wreg_o  <= 1'b0;
            ovf_o   <= 1'b0;
            wdata_o <= '0;
            wd_o    <= '0;
        end
        else
        begin
            // flags drop on idle cycles
            valid_o <= valid_i;
            wreg_o  <= valid_i && wreg_d;
            ovf_o   <= valid_i && ovf_i;
            // data held until the next valid op
            if (valid_i)
            begin
                wdata_o <= wdata_d;
                wd_o    <= wd_i;
            end
        end
    end

endmodule

/* verilog/ex_top.sv */
module ex_top (
    input  logic                              clk,
    input  logic                              rst_n_i,
    input  logic                              valid_i,
    input  ex_pkg::alu_op_e                   aluop_i,
    input  logic [ex_pkg::WORD_W-1:0]         reg1_i,
    input  logic [ex_pkg::WORD_W-1:0]         reg2_i,
    input  logic [ex_pkg::REG_ADDR_W-1:0]     wd_i,
    input  logic                              wreg_i,
    output logic                              valid_o,
    output logic [ex_pkg::WORD_W-1:0]         wdata_o,
    output logic [ex_pkg::REG_ADDR_W-1:0]     wd_o,
    output logic                              wreg_o,
    output logic                              ovf_o
);

    import ex_pkg::*;

    // unit results into the output mux
    logic [WORD_W-1:0]  logic_res;
    logic [WORD_W-1:0]  arith_res;
    logic               arith_ovf;
    logic [DWORD_W-1:0] prod_s;
    logic [DWORD_W-1:0] prod_u;
    logic [WORD_W-1:0]  hi;
    logic [WORD_W-1:0]  lo;

    // bitwise ops and shifts
    ex_logic_shift u_logic_shift (
        .aluop_i  (aluop_i),
        .reg1_i   (reg1_i),
        .reg2_i   (reg2_i),
        .result_o (logic_res)
    );

    // add, sub, compare
    ex_arith u_arith (
        .aluop_i  (aluop_i),
        .reg1_i   (reg1_i),
        .reg2_i   (reg2_i),
        .result_o (arith_res),
        .ovf_o    (arith_ovf)
    );

    // both products every cycle
    ex_mult u_mult (
        .reg1_i   (reg1_i),
        .reg2_i   (reg2_i),
        .prod_s_o (prod_s),
        .prod_u_o (prod_u)
    );

    // stage-owned hi/lo
    ex_hilo u_hilo (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .valid_i  (valid_i),
        .aluop_i  (aluop_i),
        .reg1_i   (reg1_i),
        .prod_s_i (prod_s),
        .prod_u_i (prod_u),
        .hi_o     (hi),
        .lo_o     (lo)
    );

    // class select and output register
    ex_result_mux u_result_mux (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .valid_i  (valid_i),
        .aluop_i  (aluop_i),
        .reg1_i   (reg1_i),
        .reg2_i   (reg2_i),
        .wd_i     (wd_i),
        .wreg_i   (wreg_i),
        .logic_i  (logic_res),
        .arith_i  (arith_res),
        .ovf_i    (arith_ovf),
        .prod_s_i (prod_s),
        .hi_i     (hi),
        .lo_i     (lo),
        .valid_o  (valid_o),
        .wdata_o  (wdata_o),
        .wd_o     (wd_o),
        .wreg_o   (wreg_o),
        .ovf_o    (ovf_o)
    );

endmodule

/* tests/tb_clock_gen.sv */
module tb_clock_gen (
    output logic clk_o
);

    // 20 time unit period
    localparam int HALF_PERIOD = 10;

    initial
    begin
        clk_o = 1'b0;
        forever
        begin
            #HALF_PERIOD clk_o = ~clk_o;
        end
    end

endmodule

/* tests/tb_ex_top.sv */
module tb_ex_top;

    import ex_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    localparam int MAX_ENTRIES  = 128;
    localparam int RAND_ENTRIES = 40;

    logic                  clk;
    logic                  rst_n;
    logic                  valid_in;
    alu_op_e               aluop_in;
    logic [WORD_W-1:0]     reg1_in;
    logic [WORD_W-1:0]     reg2_in;
    logic [REG_ADDR_W-1:0] wd_in;
    logic                  wreg_in;
    logic                  valid_out;
    logic [WORD_W-1:0]     wdata_out;
    logic [REG_ADDR_W-1:0] wd_out;
    logic                  wreg_out;
    logic                  ovf_out;

    // one row of stimulus and expected values per operation
    alu_op_e               op_tab[MAX_ENTRIES];
    logic [WORD_W-1:0]     a_tab[MAX_ENTRIES];
    logic [WORD_W-1:0]     b_tab[MAX_ENTRIES];
    logic [REG_ADDR_W-1:0] wd_tab[MAX_ENTRIES];
    logic                  wr_tab[MAX_ENTRIES];
    int                    gap_tab[MAX_ENTRIES];
    logic [WORD_W-1:0]     res_tab[MAX_ENTRIES];
    logic                  exp_wr_tab[MAX_ENTRIES];
    logic                  exp_ovf_tab[MAX_ENTRIES];
    int                    n_entries = 0;

    // reference hi/lo kept apart from the DUT pair
    logic [WORD_W-1:0]     ref_hi = '0;
    logic [WORD_W-1:0]     ref_lo = '0;

    logic [31:0]           rng;
    logic                  table_ready = 1'b0;
    logic                  exp_valid = 1'b0;
    int                    exp_q[$];
    logic [WORD_W-1:0]     last_wdata = '0;
    logic [REG_ADDR_W-1:0] last_wd = '0;
    int                    checks = 0;
    int                    mismatches = 0;
    int                    other_errors = 0;

    tb_clock_gen u_clock_gen (
        .clk_o (clk)
    );

    ex_top UUT (
        .clk     (clk),
        .rst_n_i (rst_n),
        .valid_i (valid_in),
        .aluop_i (aluop_in),
        .reg1_i  (reg1_in),
        .reg2_i  (reg2_in),
        .wd_i    (wd_in),
        .wreg_i  (wreg_in),
        .valid_o (valid_out),
        .wdata_o (wdata_out),
        .wd_o    (wd_out),
        .wreg_o  (wreg_out),
        .ovf_o   (ovf_out)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // random opcode with NOP left out
    function automatic alu_op_e pick_op(input int k);
        case (k)
            0:  return EXE_AND_OP;
            1:  return EXE_OR_OP;
            2:  return EXE_XOR_OP;
            3:  return EXE_NOR_OP;
            4:  return EXE_SLL_OP;
            5:  return EXE_SRL_OP;
            6:  return EXE_SRA_OP;
            7:  return EXE_ADD_OP;
            8:  return EXE_ADDU_OP;
            9:  return EXE_SUB_OP;
            10: return EXE_SUBU_OP;
            11: return EXE_SLT_OP;
            12: return EXE_SLTU_OP;
            13: return EXE_MOVZ_OP;
            14: return EXE_MOVN_OP;
            15: return EXE_MFHI_OP;
            16: return EXE_MFLO_OP;
            17: return EXE_MTHI_OP;
            18: return EXE_MTLO_OP;
            19: return EXE_MULT_OP;
            20: return EXE_MULTU_OP;
            default: return EXE_MUL_OP;
        endcase
    endfunction

    // instruction-set rules with hi/lo tracked in issue order
    task automatic ref_model(input alu_op_e op, input logic [31:0] a, input logic [31:0] b,
                             input logic wr, output logic [31:0] res, output logic wr_x,
                             output logic ov);
        logic [32:0] wide;
        logic [63:0] sx;
        logic [63:0] prod;
        res  = '0;
        ov   = 1'b0;
        wr_x = wr;
        prod = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        sx   = {{32{b[31]}}, b} >> a[4:0];
        case (op)
            EXE_AND_OP:  res = a & b;
            EXE_OR_OP:   res = a | b;
            EXE_XOR_OP:  res = a ^ b;
            EXE_NOR_OP:  res = ~(a | b);
            EXE_SLL_OP:  res = b << a[4:0];
            EXE_SRL_OP:  res = b >> a[4:0];
            EXE_SRA_OP:  res = sx[31:0];
            EXE_ADDU_OP: res = a + b;
            EXE_SUBU_OP: res = a - b;
            // differing sign bits decide the order on their own
            EXE_SLT_OP:  res = {31'b0, (a[31] != b[31]) ? a[31] : (a < b)};
            EXE_SLTU_OP: res = {31'b0, a < b};
            EXE_MFHI_OP: res = ref_hi;
            EXE_MFLO_OP: res = ref_lo;
            EXE_MTHI_OP: ref_hi = a;
            EXE_MTLO_OP: ref_lo = a;
            EXE_MULT_OP: {ref_hi, ref_lo} = prod;
            EXE_MULTU_OP: {ref_hi, ref_lo} = {32'b0, a} * {32'b0, b};
            EXE_MUL_OP:  res = prod[31:0];
            // 33-bit sums overflow when the top two bits differ
            EXE_ADD_OP:
            begin
                wide = {a[31], a} + {b[31], b};
                res  = wide[31:0];
                ov   = wide[32] ^ wide[31];
            end
            EXE_SUB_OP:
            begin
                wide = {a[31], a} - {b[31], b};
                res  = wide[31:0];
                ov   = wide[32] ^ wide[31];
            end
            EXE_MOVZ_OP:
            begin
                res = a;
                wr_x = wr && (b == 0);
            end
            EXE_MOVN_OP:
            begin
                res = a;
                wr_x = wr && (b != 0);
            end
            default:     res = '0;
        endcase
        if (ov)
            wr_x = 1'b0;
    endtask

    task automatic add_entry(input alu_op_e op, input logic [31:0] a, input logic [31:0] b,
                             input logic wr, input int gap);
        logic [31:0] res;
        logic        wr_x;
        logic        ov;
        ref_model(op, a, b, wr, res, wr_x, ov);
        op_tab[n_entries]      = op;
        a_tab[n_entries]       = a;
        b_tab[n_entries]       = b;
        wr_tab[n_entries]      = wr;
        wd_tab[n_entries]      = REG_ADDR_W'(n_entries * 7);
        gap_tab[n_entries]     = gap;
        res_tab[n_entries]     = res;
        exp_wr_tab[n_entries]  = wr_x;
        exp_ovf_tab[n_entries] = ov;
        n_entries++;
    endtask

    task automatic build_table();
        logic [31:0] r;
        logic [31:0] b;
        // hi/lo must read zero right after reset
        add_entry(EXE_MFHI_OP, 32'h0, 32'h0, 1'b1, 0);
        add_entry(EXE_MFLO_OP, 32'h0, 32'h0, 1'b1, 0);
        add_entry(EXE_AND_OP, 32'hF0F0_1234, 32'h0FF0_AAAA, 1'b1, 0);
        add_entry(EXE_OR_OP,  32'hF0F0_1234, 32'h0FF0_AAAA, 1'b1, 0);
        add_entry(EXE_XOR_OP, 32'hF0F0_1234, 32'h0FF0_AAAA, 1'b1, 0);
        add_entry(EXE_NOR_OP, 32'hF0F0_1234, 32'h0FF0_AAAA, 1'b1, 0);
        // upper amount bits ignored in the SRL case
        add_entry(EXE_SLL_OP, 32'h0000_0004, 32'h8000_0001, 1'b1, 0);
        add_entry(EXE_SRL_OP, 32'h0000_0023, 32'h8000_00F0, 1'b1, 0);
        add_entry(EXE_SRA_OP, 32'h0000_0008, 32'h8765_4321, 1'b1, 0);
        add_entry(EXE_SRA_OP, 32'h0000_0004, 32'h1234_5678, 1'b1, 0);
        // overflowing pairs in trapping and wrapping forms
        add_entry(EXE_ADD_OP,  32'h7FFF_FFFF, 32'h0000_0001, 1'b1, 0);
        add_entry(EXE_ADDU_OP, 32'h7FFF_FFFF, 32'h0000_0001, 1'b1, 0);
        add_entry(EXE_ADD_OP,  32'h8000_0000, 32'h8000_0000, 1'b1, 0);
        add_entry(EXE_SUB_OP,  32'h8000_0000, 32'h0000_0001, 1'b1, 0);
        add_entry(EXE_SUBU_OP, 32'h8000_0000, 32'h0000_0001, 1'b1, 0);
        add_entry(EXE_SUB_OP,  32'h7FFF_FFFF, 32'hFFFF_FFFF, 1'b1, 0);
        add_entry(EXE_ADD_OP,  32'h0000_0005, 32'hFFFF_FFFD, 1'b1, 0);
        // mixed signs where signed and unsigned order differ
        add_entry(EXE_SLT_OP,  32'hFFFF_FFFF, 32'h0000_0001, 1'b1, 0);
        add_entry(EXE_SLTU_OP, 32'hFFFF_FFFF, 32'h0000_0001, 1'b1, 0);
        add_entry(EXE_SLT_OP,  32'h0000_0001, 32'hFFFF_FFFF, 1'b1, 0);
        add_entry(EXE_SLTU_OP, 32'h0000_0001, 32'hFFFF_FFFF, 1'b1, 0);
        // products read back in the next cycles
        add_entry(EXE_MULT_OP,  32'hFFFF_FFFE, 32'h1234_5678, 1'b0, 0);
        add_entry(EXE_MFHI_OP,  32'h0, 32'h0, 1'b1, 0);
        add_entry(EXE_MFLO_OP,  32'h0, 32'h0, 1'b1, 0);
        add_entry(EXE_MULTU_OP, 32'hFFFF_FFFE, 32'h1234_5678, 1'b0, 0);
        add_entry(EXE_MFHI_OP,  32'h0, 32'h0, 1'b1, 0);
        add_entry(EXE_MFLO_OP,  32'h0, 32'h0, 1'b1, 0);
        add_entry(EXE_MTHI_OP,  32'hDEAD_BEEF, 32'h0, 1'b0, 0);
        add_entry(EXE_MFHI_OP,  32'h0, 32'h0, 1'b1, 0);
        add_entry(EXE_MFLO_OP,  32'h0, 32'h0, 1'b1, 0);
        add_entry(EXE_MTLO_OP,  32'h0BAD_F00D, 32'h0, 1'b0, 0);
        add_entry(EXE_MFLO_OP,  32'h0, 32'h0, 1'b1, 0);
        add_entry(EXE_MFHI_OP,  32'h0, 32'h0, 1'b1, 0);
        // MUL leaves the pair alone
        add_entry(EXE_MUL_OP,   32'hFFFF_FFFD, 32'h0000_0007, 1'b1, 0);
        add_entry(EXE_MFHI_OP,  32'h0, 32'h0, 1'b1, 0);
        add_entry(EXE_MFLO_OP,  32'h0, 32'h0, 1'b1, 0);
        add_entry(EXE_MOVZ_OP,  32'h0000_1111, 32'h0, 1'b1, 0);
        add_entry(EXE_MOVZ_OP,  32'h0000_2222, 32'h5, 1'b1, 0);
        add_entry(EXE_MOVN_OP,  32'h0000_3333, 32'h0, 1'b1, 0);
        add_entry(EXE_MOVN_OP,  32'h0000_4444, 32'h9, 1'b1, 0);
        add_entry(EXE_NOP_OP,   32'h0, 32'h0, 1'b0, 0);
        // gapped runs with junk MTHI on the idle cycles
        add_entry(EXE_AND_OP,  32'hFFFF_0000, 32'h1234_5678, 1'b1, 2);
        add_entry(EXE_MFHI_OP, 32'h0, 32'h0, 1'b1, 3);
        add_entry(EXE_MFLO_OP, 32'h0, 32'h0, 1'b1, 1);
        for (int k = 0; k < RAND_ENTRIES; k++)
        begin
            rng = xorshift32(rng);
            r   = rng;
            rng = xorshift32(rng);
            // zero operand 2 now and then for the moves
            b   = (r[7:5] == 3'd0) ? 32'h0 : rng;
            rng = xorshift32(rng);
            add_entry(pick_op(int'(r % 22)), rng, b, r[8], (r[15:12] == 4'd0) ? 1 : 0);
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            $display("mismatch at time %0t: %s got %08h expected %08h", $time, what, got, exp);
            mismatches++;
        end
    endtask

    // one-cycle stage latency as seen from the testbench
    always @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            exp_valid <= 1'b0;
        else
            exp_valid <= valid_in;
    end

    // outputs sampled mid-cycle
    always @(negedge clk)
    begin
        int idx;
        if (exp_valid)
        begin
            idx = exp_q.pop_front();
            if (valid_out !== 1'b1)
            begin
                $display("error at time %0t: valid_o missing for entry %0d", $time, idx);
                other_errors++;
            end
            else
            begin
                check_value($sformatf("entry %0d wdata_o", idx), wdata_out, res_tab[idx]);
                check_value($sformatf("entry %0d wd_o", idx), 32'(wd_out), 32'(wd_tab[idx]));
                check_value($sformatf("entry %0d wreg_o", idx), 32'(wreg_out),
                            32'(exp_wr_tab[idx]));
                check_value($sformatf("entry %0d ovf_o", idx), 32'(ovf_out),
                            32'(exp_ovf_tab[idx]));
                last_wdata = wdata_out;
                last_wd    = wd_out;
            end
        end
        else if (valid_out !== 1'b0)
        begin
            $display("error at time %0t: valid_o raised with no operation issued", $time);
            other_errors++;
        end
        else
        begin
            // idle cycle with flags low and data held
            check_value("idle wreg_o", 32'(wreg_out), 32'h0);
            check_value("idle ovf_o", 32'(ovf_out), 32'h0);
            check_value("idle wdata_o", wdata_out, last_wdata);
            check_value("idle wd_o", 32'(wd_out), 32'(last_wd));
        end
    end

    initial
    begin
        longint limit;
        wait (table_ready);
        limit = longint'(n_entries + RESET_CYCLES + 50) * CLK_PERIOD;
        #(limit);
        $display("timeout: the run did not finish within %0d time units", limit);
        $display("Errors found");
        $finish;
    end

    initial
    begin
        rst_n    = 1'b0;
        valid_in = 1'b0;
        aluop_in = EXE_NOP_OP;
        reg1_in  = '0;
        reg2_in  = '0;
        wd_in    = '0;
        wreg_in  = 1'b0;
        rng      = 32'd8485;
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        for (int i = 0; i < n_entries; i++)
        begin
            repeat (gap_tab[i])
            begin
                @(posedge clk);
                rng = xorshift32(rng);
                valid_in <= 1'b0;
                aluop_in <= EXE_MTHI_OP;
                reg1_in  <= rng;
            end
            @(posedge clk);
            valid_in <= 1'b1;
            aluop_in <= op_tab[i];
            reg1_in  <= a_tab[i];
            reg2_in  <= b_tab[i];
            wd_in    <= wd_tab[i];
            wreg_in  <= wr_tab[i];
            exp_q.push_back(i);
        end
        @(posedge clk);
        valid_in <= 1'b0;
        repeat (3) @(posedge clk);
        if (exp_q.size() != 0)
        begin
            $display("error: %0d operations never produced valid_o", exp_q.size());
            other_errors++;
        end
        $display("summary: %0d checks, %0d mismatches, %0d other failures",
                 checks, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

/* sim.f */
verilog/ex_pkg.sv
verilog/ex_logic_shift.sv
verilog/ex_arith.sv
verilog/ex_mult.sv
verilog/ex_hilo.sv
verilog/ex_result_mux.sv
verilog/ex_top.sv
tests/tb_clock_gen.sv
tests/tb_ex_top.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module tb_ex_top -f sim.f
	out="$$(./obj_dir/Vtb_ex_top)"; echo "$$out"; echo "$$out" | grep -q "No errors"

clean:
	rm -rf obj_dir
